/* src/sparc_id_config.svh */
`ifndef SPARC_ID_CONFIG_SVH
`define SPARC_ID_CONFIG_SVH

// ==========================================================================
// Datapath and register file geometry
// ==========================================================================
`define SPARC_XLEN      32
`define SPARC_NREGS     32
`define SPARC_REG_W     5

// CALL saves its return address here
`define SPARC_LINK_REG  15

// ==========================================================================
// Immediate and displacement fields
// ==========================================================================
`define SPARC_IMM22_W   22
`define SPARC_DISP30_W  30

`endif

/* src/sparc_id_pkg.sv */
package sparc_id_pkg;

    // Primary opcode in instruction bits 31:30
    typedef enum logic [1:0] {
        FMT_BRANCH = 2'b00,
        FMT_CALL   = 2'b01,
        FMT_ARITH  = 2'b10,
        FMT_MEM    = 2'b11
    } op_format_t;

    // ALU operation seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_ADDX = 4'b0001,
        ALU_SUB  = 4'b0010,
        ALU_SUBX = 4'b0011,
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_XNOR = 4'b0111,
        ALU_ANDN = 4'b1000,
        ALU_SLL  = 4'b1010,
        ALU_SRL  = 4'b1011,
        ALU_SRA  = 4'b1100
    } alu_op_t;

    // Second operand source
    typedef enum logic [3:0] {
        SRC_NONE  = 4'b0000,
        SRC_IMM22 = 4'b0100,
        SRC_REG   = 4'b1000,
        SRC_IMM13 = 4'b1001
    } operand_src_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_t;

    // Operand select from the hazard unit
    typedef enum logic [1:0] {
        FWD_FILE = 2'b00,
        FWD_EX   = 2'b01,
        FWD_MEM  = 2'b10,
        FWD_WB   = 2'b11
    } fwd_sel_t;

endpackage

/* src/id_decoder.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module id_decoder
    import sparc_id_pkg::*;
(
    input  logic [31:0]             instruction,
    output alu_op_t                 alu_op,
    output operand_src_t            op2_src,
    output logic                    load,
    output logic                    store,
    output logic                    mem_enable,
    output logic                    signed_load,
    output logic                    annul,
    output logic                    reg_write,
    output logic                    psr_write,
    output logic                    is_call,
    output logic                    is_branch,
    output logic                    is_jmpl,
    output mem_size_t               mem_size,
    output logic [`SPARC_REG_W-1:0] dest_reg
);

    op_format_t              op;
    logic [2:0]              op2;
    logic [5:0]              op3;
    logic                    a_bit;
    logic                    i_bit;
    logic [`SPARC_REG_W-1:0] rd;
    logic                    arith_ok;
    logic                    mem_ok;

    // Instruction fields
    assign op    = op_format_t'(instruction[31:30]);
    assign rd    = instruction[29:25];
    assign a_bit = instruction[29];
    assign op2   = instruction[24:22];
    assign op3   = instruction[24:19];
    assign i_bit = instruction[13];

    assign dest_reg = is_call ? `SPARC_REG_W'(`SPARC_LINK_REG) : rd;

    always_comb begin
        alu_op      = ALU_ADD;
        op2_src     = SRC_NONE;
        load        = 1'b0;
        store       = 1'b0;
        mem_enable  = 1'b0;
        signed_load = 1'b0;
        annul       = 1'b0;
        reg_write   = 1'b0;
        psr_write   = 1'b0;
        is_call     = 1'b0;
        is_branch   = 1'b0;
        is_jmpl     = 1'b0;
        mem_size    = SIZE_BYTE;
        arith_ok    = 1'b0;
        mem_ok      = 1'b0;

        // All-zero word is the NOP
        if (instruction != '0) begin
            case (op)
                FMT_CALL: begin
                    is_call   = 1'b1;
                    reg_write = 1'b1;
                end

                FMT_BRANCH: begin
                    if (op2 == 3'b100) begin
                        // SETHI
                        reg_write = 1'b1;
                        op2_src   = SRC_IMM22;
                    end else if (op2 == 3'b010) begin
                        // Bicc whose condition is resolved later
                        is_branch = 1'b1;
                        annul     = a_bit;
                    end
                end

                // ==========================================================
                // Arithmetic, logic, shift and JMPL
                // ==========================================================
                FMT_ARITH: begin
                    arith_ok = 1'b1;
                    // Bit 4 of op3 selects the cc variant
                    casez (op3)
                        6'b0?0000: alu_op = ALU_ADD;
                        6'b0?1000: alu_op = ALU_ADDX;
                        6'b0?0100: alu_op = ALU_SUB;
                        6'b0?1100: alu_op = ALU_SUBX;
                        6'b0?0001: alu_op = ALU_AND;
                        6'b0?0010: alu_op = ALU_OR;
                        6'b0?0011: alu_op = ALU_XOR;
                        6'b0?0111: alu_op = ALU_XNOR;
                        6'b0?0101: alu_op = ALU_ANDN;
                        6'b100101: alu_op = ALU_SLL;
                        6'b100110: alu_op = ALU_SRL;
                        6'b100111: alu_op = ALU_SRA;
                        6'b111000: is_jmpl = 1'b1;
                        default:   arith_ok = 1'b0;
                    endcase
                    reg_write = arith_ok;
                    psr_write = arith_ok & ~op3[5] & op3[4];
                    if (arith_ok) begin
                        op2_src = i_bit ? SRC_IMM13 : SRC_REG;
                    end
                end

                // ==========================================================
                // Loads and stores
                // ==========================================================
                FMT_MEM: begin
                    mem_ok = 1'b1;
                    case (op3)
                        6'b000000: begin
                            load     = 1'b1;
                            mem_size = SIZE_WORD;
                        end
                        6'b000001: load = 1'b1;
                        6'b000010: begin
                            load     = 1'b1;
                            mem_size = SIZE_HALF;
                        end
                        6'b001001: begin
                            load        = 1'b1;
                            signed_load = 1'b1;
                        end
                        6'b001010: begin
                            load        = 1'b1;
                            signed_load = 1'b1;
                            mem_size    = SIZE_HALF;
                        end
                        6'b000100: begin
                            store    = 1'b1;
                            mem_size = SIZE_WORD;
                        end
                        6'b000101: store = 1'b1;
                        6'b000110: begin
                            store    = 1'b1;
                            mem_size = SIZE_HALF;
                        end
                        default:   mem_ok = 1'b0;
                    endcase
                    mem_enable = mem_ok;
                    reg_write  = load;
                    if (mem_ok) begin
                        op2_src = i_bit ? SRC_IMM13 : SRC_REG;
                    end
                end
            endcase
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module register_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    write,
    input  logic [`SPARC_REG_W-1:0] write_reg,
    input  logic [`SPARC_XLEN-1:0]  write_data,
    input  logic [`SPARC_REG_W-1:0] read_reg_a,
    input  logic [`SPARC_REG_W-1:0] read_reg_b,
    input  logic [`SPARC_REG_W-1:0] read_reg_c,
    output logic [`SPARC_XLEN-1:0]  read_a,
    output logic [`SPARC_XLEN-1:0]  read_b,
    output logic [`SPARC_XLEN-1:0]  read_c
);

    logic [`SPARC_XLEN-1:0] regs [`SPARC_NREGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SPARC_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && write_reg != '0) begin
            regs[write_reg] <= write_data;
        end
    end

    // Asynchronous reads with r0 hardwired to zero
    assign read_a = (read_reg_a == '0) ? '0 : regs[read_reg_a];
    assign read_b = (read_reg_b == '0) ? '0 : regs[read_reg_b];
    assign read_c = (read_reg_c == '0) ? '0 : regs[read_reg_c];

endmodule

/* src/operand_forward.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module operand_forward
    import sparc_id_pkg::*;
(
    input  logic [`SPARC_XLEN-1:0] file_a,
    input  logic [`SPARC_XLEN-1:0] file_b,
    input  logic [`SPARC_XLEN-1:0] file_c,
    input  logic [`SPARC_XLEN-1:0] ex_result,
    input  logic [`SPARC_XLEN-1:0] mem_result,
    input  logic [`SPARC_XLEN-1:0] wb_result,
    input  fwd_sel_t               sel_a,
    input  fwd_sel_t               sel_b,
    input  fwd_sel_t               sel_c,
    output logic [`SPARC_XLEN-1:0] op_a,
    output logic [`SPARC_XLEN-1:0] op_b,
    output logic [`SPARC_XLEN-1:0] op_c
);

    // One 4-way select shared by all three operands
    function automatic logic [`SPARC_XLEN-1:0] pick(
        input fwd_sel_t               sel,
        input logic [`SPARC_XLEN-1:0] from_file,
        input logic [`SPARC_XLEN-1:0] from_ex,
        input logic [`SPARC_XLEN-1:0] from_mem,
        input logic [`SPARC_XLEN-1:0] from_wb
    );
        case (sel)
            FWD_EX:  return from_ex;
            FWD_MEM: return from_mem;
            FWD_WB:  return from_wb;
            default: return from_file;
        endcase
    endfunction

    assign op_a = pick(sel_a, file_a, ex_result, mem_result, wb_result);
    assign op_b = pick(sel_b, file_b, ex_result, mem_result, wb_result);
    assign op_c = pick(sel_c, file_c, ex_result, mem_result, wb_result);

endmodule

/* src/branch_target.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module branch_target (
    input  logic [`SPARC_XLEN-1:0] pc,
    input  logic [31:0]            instruction,
    input  logic                   is_call,
    input  logic                   is_branch,
    output logic [`SPARC_XLEN-1:0] target_addr
);

    logic [`SPARC_XLEN-1:0] call_offset;
    logic [`SPARC_XLEN-1:0] branch_offset;

    // Word displacements turned into byte offsets
    assign call_offset = {instruction[`SPARC_DISP30_W-1:0], 2'b00};
    assign branch_offset = {{(`SPARC_XLEN - `SPARC_IMM22_W - 2){instruction[`SPARC_IMM22_W-1]}},
                            instruction[`SPARC_IMM22_W-1:0], 2'b00};

    always_comb begin
        if (is_call) begin
            target_addr = pc + call_offset;
        end else if (is_branch) begin
            target_addr = pc + branch_offset;
        end else begin
            target_addr = '0;
        end
    end

endmodule

/* src/id_ex_register.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module id_ex_register
    import sparc_id_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       stall,
    input  alu_op_t                    alu_op,
    input  operand_src_t               op2_src,
    input  logic                       load,
    input  logic                       store,
    input  logic                       mem_enable,
    input  mem_size_t                  mem_size,
    input  logic                       signed_load,
    input  logic                       annul,
    input  logic                       reg_write,
    input  logic                       psr_write,
    input  logic                       is_call,
    input  logic [`SPARC_XLEN-1:0]     op_a,
    input  logic [`SPARC_XLEN-1:0]     op_b,
    input  logic [`SPARC_XLEN-1:0]     op_c,
    input  logic [`SPARC_REG_W-1:0]    dest_reg,
    input  logic [`SPARC_IMM22_W-1:0]  imm22,
    output alu_op_t                    ex_alu_op,
    output operand_src_t               ex_op2_src,
    output logic                       ex_load,
    output logic                       ex_store,
    output logic                       ex_mem_enable,
    output mem_size_t                  ex_mem_size,
    output logic                       ex_signed_load,
    output logic                       ex_annul,
    output logic                       ex_reg_write,
    output logic                       ex_psr_write,
    output logic                       ex_call,
    output logic [`SPARC_XLEN-1:0]     ex_a,
    output logic [`SPARC_XLEN-1:0]     ex_b,
    output logic [`SPARC_XLEN-1:0]     ex_c,
    output logic [`SPARC_REG_W-1:0]    ex_rd,
    output logic [`SPARC_IMM22_W-1:0]  ex_imm22
);

    // A stall loads the controls with a bubble equal to the reset state
    always_ff @(posedge clk) begin
        if (reset || stall) begin
            ex_alu_op      <= ALU_ADD;
            ex_op2_src     <= SRC_NONE;
            ex_load        <= 1'b0;
            ex_store       <= 1'b0;
            ex_mem_enable  <= 1'b0;
            ex_mem_size    <= SIZE_BYTE;
            ex_signed_load <= 1'b0;
            ex_annul       <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_psr_write   <= 1'b0;
            ex_call        <= 1'b0;
        end else begin
            ex_alu_op      <= alu_op;
            ex_op2_src     <= op2_src;
            ex_load        <= load;
            ex_store       <= store;
            ex_mem_enable  <= mem_enable;
            ex_mem_size    <= mem_size;
            ex_signed_load <= signed_load;
            ex_annul       <= annul;
            ex_reg_write   <= reg_write;
            ex_psr_write   <= psr_write;
            ex_call        <= is_call;
        end
    end

    // Operands and fields keep flowing during a stall
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_a     <= '0;
            ex_b     <= '0;
            ex_c     <= '0;
            ex_rd    <= '0;
            ex_imm22 <= '0;
        end else begin
            ex_a     <= op_a;
            ex_b     <= op_b;
            ex_c     <= op_c;
            ex_rd    <= dest_reg;
            ex_imm22 <= imm22;
        end
    end

endmodule

/* src/id_stage.sv */
`timescale 1ns/10ps
`include "sparc_id_config.svh"

module id_stage
    import sparc_id_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [31:0]                instruction,
    input  logic [`SPARC_XLEN-1:0]     pc,
    input  logic                       wb_write,
    input  logic [`SPARC_REG_W-1:0]    wb_reg,
    input  logic [`SPARC_XLEN-1:0]     wb_data,
    input  logic [`SPARC_XLEN-1:0]     ex_result,
    input  logic [`SPARC_XLEN-1:0]     mem_result,
    input  logic [`SPARC_XLEN-1:0]     wb_result,
    input  fwd_sel_t                   sel_a,
    input  fwd_sel_t                   sel_b,
    input  fwd_sel_t                   sel_c,
    input  logic                       stall,
    output logic [`SPARC_XLEN-1:0]     target_addr,
    output logic                       is_call,
    output logic                       is_branch,
    output logic                       is_jmpl,
    output alu_op_t                    ex_alu_op,
    output operand_src_t               ex_op2_src,
    output logic                       ex_load,
    output logic                       ex_store,
    output logic                       ex_mem_enable,
    output mem_size_t                  ex_mem_size,
    output logic                       ex_signed_load,
    output logic                       ex_annul,
    output logic                       ex_reg_write,
    output logic                       ex_psr_write,
    output logic                       ex_call,
    output logic [`SPARC_XLEN-1:0]     ex_a,
    output logic [`SPARC_XLEN-1:0]     ex_b,
    output logic [`SPARC_XLEN-1:0]     ex_c,
    output logic [`SPARC_REG_W-1:0]    ex_rd,
    output logic [`SPARC_IMM22_W-1:0]  ex_imm22
);

    alu_op_t                 alu_op;
    operand_src_t            op2_src;
    mem_size_t               mem_size;
    logic                    load;
    logic                    store;
    logic                    mem_enable;
    logic                    signed_load;
    logic                    annul;
    logic                    reg_write;
    logic                    psr_write;
    logic [`SPARC_REG_W-1:0] dest_reg;
    logic [`SPARC_XLEN-1:0]  file_a;
    logic [`SPARC_XLEN-1:0]  file_b;
    logic [`SPARC_XLEN-1:0]  file_c;
    logic [`SPARC_XLEN-1:0]  op_a;
    logic [`SPARC_XLEN-1:0]  op_b;
    logic [`SPARC_XLEN-1:0]  op_c;

    id_decoder u_decoder (
        .instruction (instruction),
        .alu_op      (alu_op),
        .op2_src     (op2_src),
        .load        (load),
        .store       (store),
        .mem_enable  (mem_enable),
        .signed_load (signed_load),
        .annul       (annul),
        .reg_write   (reg_write),
        .psr_write   (psr_write),
        .is_call     (is_call),
        .is_branch   (is_branch),
        .is_jmpl     (is_jmpl),
        .mem_size    (mem_size),
        .dest_reg    (dest_reg)
    );

    // Read ports follow rs1, rs2 and rd
    register_file u_regfile (
        .clk        (clk),
        .reset      (reset),
        .write      (wb_write),
        .write_reg  (wb_reg),
        .write_data (wb_data),
        .read_reg_a (instruction[18:14]),
        .read_reg_b (instruction[4:0]),
        .read_reg_c (instruction[29:25]),
        .read_a     (file_a),
        .read_b     (file_b),
        .read_c     (file_c)
    );

    operand_forward u_forward (
        .file_a     (file_a),
        .file_b     (file_b),
        .file_c     (file_c),
        .ex_result  (ex_result),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .sel_a      (sel_a),
        .sel_b      (sel_b),
        .sel_c      (sel_c),
        .op_a       (op_a),
        .op_b       (op_b),
        .op_c       (op_c)
    );

    branch_target u_target (
        .pc          (pc),
        .instruction (instruction),
        .is_call     (is_call),
        .is_branch   (is_branch),
        .target_addr (target_addr)
    );

    id_ex_register u_id_ex (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .alu_op         (alu_op),
        .op2_src        (op2_src),
        .load           (load),
        .store          (store),
        .mem_enable     (mem_enable),
        .mem_size       (mem_size),
        .signed_load    (signed_load),
        .annul          (annul),
        .reg_write      (reg_write),
        .psr_write      (psr_write),
        .is_call        (is_call),
        .op_a           (op_a),
        .op_b           (op_b),
        .op_c           (op_c),
        .dest_reg       (dest_reg),
        .imm22          (instruction[`SPARC_IMM22_W-1:0]),
        .ex_alu_op      (ex_alu_op),
        .ex_op2_src     (ex_op2_src),
        .ex_load        (ex_load),
        .ex_store       (ex_store),
        .ex_mem_enable  (ex_mem_enable),
        .ex_mem_size    (ex_mem_size),
        .ex_signed_load (ex_signed_load),
        .ex_annul       (ex_annul),
        .ex_reg_write   (ex_reg_write),
        .ex_psr_write   (ex_psr_write),
        .ex_call        (ex_call),
        .ex_a           (ex_a),
        .ex_b           (ex_b),
        .ex_c           (ex_c),
        .ex_rd          (ex_rd),
        .ex_imm22       (ex_imm22)
    );

endmodule

/* tb/tb_id_stage.sv */
`timescale 1ns/10ps

module tb_id_stage
    import sparc_id_pkg::*;
();

    localparam int num_vectors  = 24;
    localparam int read_timeout = 200;

    // DUT inputs
    logic         clk;
    logic         reset;
    logic [31:0]  instruction;
    logic [31:0]  pc;
    logic         wb_write;
    logic [4:0]   wb_reg;
    logic [31:0]  wb_data;
    logic [31:0]  ex_result;
    logic [31:0]  mem_result;
    logic [31:0]  wb_result;
    fwd_sel_t     sel_a;
    fwd_sel_t     sel_b;
    fwd_sel_t     sel_c;
    logic         stall;

    // DUT outputs
    logic [31:0]  target_addr;
    logic         is_call;
    logic         is_branch;
    logic         is_jmpl;
    alu_op_t      ex_alu_op;
    operand_src_t ex_op2_src;
    logic         ex_load;
    logic         ex_store;
    logic         ex_mem_enable;
    mem_size_t    ex_mem_size;
    logic         ex_signed_load;
    logic         ex_annul;
    logic         ex_reg_write;
    logic         ex_psr_write;
    logic         ex_call;
    logic [31:0]  ex_a;
    logic [31:0]  ex_b;
    logic [31:0]  ex_c;
    logic [4:0]   ex_rd;
    logic [21:0]  ex_imm22;

    // Current vector as stimulus followed by expected values
    logic [31:0]  v_instr, v_pc, v_wb_write, v_wb_reg, v_wb_data, v_ex_result;
    logic [31:0]  v_mem_result, v_wb_result, v_sel_a, v_sel_b, v_sel_c, v_stall;
    logic [31:0]  e_target, e_reg_write, e_load, e_store, e_size, e_alu_op;
    logic [31:0]  e_psr_write, e_annul, e_signed_load, e_a, e_b, e_rd;

    // Register contents after all write-backs seen so far
    logic [31:0]  model_regs [32];

    int              errors;
    int              checks;
    int              vectors;
    int              cycles;
    int              fd;
    int              n;
    bit              finished;
    string           name;
    logic [8*160-1:0] comment_rest;

    id_stage dut (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    // Operand value for a select of file, execute, memory or write-back
    function automatic logic [31:0] selected_source(input fwd_sel_t sel,
                                                    input logic [31:0] from_file);
        case (sel)
            FWD_EX:  return v_ex_result;
            FWD_MEM: return v_mem_result;
            FWD_WB:  return v_wb_result;
            default: return from_file;
        endcase
    endfunction

    // ==========================================================================
    // Drive one vector and let the ID/EX register take it
    // ==========================================================================
    task automatic apply_vector();
        @(posedge clk);
        instruction <= v_instr;
        pc          <= v_pc;
        wb_write    <= v_wb_write[0];
        wb_reg      <= v_wb_reg[4:0];
        wb_data     <= v_wb_data;
        ex_result   <= v_ex_result;
        mem_result  <= v_mem_result;
        wb_result   <= v_wb_result;
        sel_a       <= fwd_sel_t'(v_sel_a[1:0]);
        sel_b       <= fwd_sel_t'(v_sel_b[1:0]);
        sel_c       <= fwd_sel_t'(v_sel_c[1:0]);
        stall       <= v_stall[0];
        @(posedge clk);
        // Inputs are still held, so target_addr belongs to this vector too
        @(negedge clk);
    endtask

    task automatic check_outputs(input string test);
        logic [1:0]   op;
        logic         e_call;
        logic         e_branch;
        logic         e_jmpl;
        logic         format3_ok;
        operand_src_t e_op2_src;
        logic [31:0]  e_c;

        op       = v_instr[31:30];
        e_call   = (op == 2'b01);
        e_branch = (op == 2'b00) && (v_instr[24:22] == 3'b010);
        e_jmpl   = (op == 2'b10) && (v_instr[24:19] == 6'b111000);

        // Kept format-3 instructions take rs2 or simm13 by the i bit
        format3_ok = (op == 2'b10 && e_reg_write[0]) ||
                     (op == 2'b11 && (e_load[0] || e_store[0]));
        if (format3_ok) begin
            e_op2_src = v_instr[13] ? SRC_IMM13 : SRC_REG;
        end else if (op == 2'b00 && v_instr[24:22] == 3'b100 && !v_stall[0]) begin
            e_op2_src = SRC_IMM22;
        end else begin
            e_op2_src = SRC_NONE;
        end
        e_c = selected_source(fwd_sel_t'(v_sel_c[1:0]), model_regs[v_instr[29:25]]);

        check_value(test, "target_addr", e_target, target_addr);
        check_value(test, "is_call", {31'd0, e_call}, {31'd0, is_call});
        check_value(test, "is_branch", {31'd0, e_branch}, {31'd0, is_branch});
        check_value(test, "is_jmpl", {31'd0, e_jmpl}, {31'd0, is_jmpl});
        check_value(test, "ex_reg_write", e_reg_write, {31'd0, ex_reg_write});
        check_value(test, "ex_load", e_load, {31'd0, ex_load});
        check_value(test, "ex_store", e_store, {31'd0, ex_store});
        check_value(test, "ex_mem_enable", e_load | e_store, {31'd0, ex_mem_enable});
        check_value(test, "ex_mem_size", e_size, {30'd0, ex_mem_size});
        check_value(test, "ex_alu_op", e_alu_op, {28'd0, ex_alu_op});
        check_value(test, "ex_op2_src", {28'd0, e_op2_src}, {28'd0, ex_op2_src});
        check_value(test, "ex_psr_write", e_psr_write, {31'd0, ex_psr_write});
        check_value(test, "ex_annul", e_annul, {31'd0, ex_annul});
        check_value(test, "ex_signed_load", e_signed_load, {31'd0, ex_signed_load});
        check_value(test, "ex_call", {31'd0, e_call & ~v_stall[0]}, {31'd0, ex_call});
        check_value(test, "ex_a", e_a, ex_a);
        check_value(test, "ex_b", e_b, ex_b);
        check_value(test, "ex_c", e_c, ex_c);
        check_value(test, "ex_rd", e_rd, {27'd0, ex_rd});
        check_value(test, "ex_imm22", {10'd0, v_instr[21:0]}, {10'd0, ex_imm22});
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        instruction = '0;
        pc          = '0;
        wb_write    = 1'b0;
        wb_reg      = '0;
        wb_data     = '0;
        ex_result   = '0;
        mem_result  = '0;
        wb_result   = '0;
        sel_a       = FWD_FILE;
        sel_b       = FWD_FILE;
        sel_c       = FWD_FILE;
        stall       = 1'b0;
        errors      = 0;
        checks      = 0;
        vectors     = 0;
        cycles      = 0;
        finished    = 1'b0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/id_stage_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file tb/id_stage_testdata.txt");
            errors++;
            finished = 1'b1;
        end

        // ==========================================================================
        // Vector loop bounded in cycles
        // ==========================================================================
        while (!finished) begin
            if (cycles >= read_timeout) begin
                $display("timeout: test data not finished after %0d cycles", cycles);
                errors++;
                finished = 1'b1;
            end else begin
                n = $fscanf(fd, "%s", name);
                if (n != 1) begin
                    finished = 1'b1;
                end else if (name.substr(0, 0) == "#") begin
                    n = $fgets(comment_rest, fd);
                end else begin
                    n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                v_instr, v_pc, v_wb_write, v_wb_reg, v_wb_data,
                                v_ex_result, v_mem_result, v_wb_result,
                                v_sel_a, v_sel_b, v_sel_c, v_stall);
                    n += $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                 e_target, e_reg_write, e_load, e_store, e_size,
                                 e_alu_op, e_psr_write, e_annul, e_signed_load,
                                 e_a, e_b, e_rd);
                    if (n != 24) begin
                        $display("vector %s in the test data is incomplete", name);
                        errors++;
                        finished = 1'b1;
                    end else begin
                        apply_vector();
                        check_outputs(name);
                        // The write lands on the same edge that reads the old value
                        if (v_wb_write[0] && v_wb_reg[4:0] != 5'd0) begin
                            model_regs[v_wb_reg[4:0]] = v_wb_data;
                        end
                        vectors++;
                        cycles += 2;
                    end
                end
            end
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        if (vectors < num_vectors) begin
            $display("test data ran out after %0d of %0d vectors", vectors, num_vectors);
            errors++;
        end

        $display("%0d vectors, %0d checks, %0d errors", vectors, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* id_stage.f */
+incdir+src
src/sparc_id_pkg.sv
src/id_decoder.sv
src/register_file.sv
src/operand_forward.sv
src/branch_target.sv
src/id_ex_register.sv
src/id_stage.sv
tb/tb_id_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the id_stage testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_binary=tb_id_stage_sim
log_file=sim.log

verilator --binary --timing -f id_stage.f --top-module tb_id_stage \
    --Mdir "$build_dir" -o "$sim_binary"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_binary" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" "$log_file"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* tb/id_stage_testdata.txt */
# name instr pc wb_write wb_reg wb_data ex_result mem_result wb_result sel_a sel_b sel_c stall
#   then target ex_reg_write ex_load ex_store size alu_op psr_write annul signed_load ex_a ex_b ex_rd
wr_r5         00000000 00000100 1 05 cafe0005 11111111 22222222 33333333 0 0 0 0
    00000000 0 0 0 0 0 0 0 0 00000000 00000000 00
wr_r6         00000000 00000100 1 06 0bad0006 11111111 22222222 33333333 0 0 0 0
    00000000 0 0 0 0 0 0 0 0 00000000 00000000 00
wr_r0         00000000 00000100 1 00 deadbeef 11111111 22222222 33333333 0 0 0 0
    00000000 0 0 0 0 0 0 0 0 00000000 00000000 00
rd_r5_r6      82014006 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 0 0 0 cafe0005 0bad0006 01
rd_r0         84000000 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 0 0 0 00000000 00000000 02
add_imm       86016064 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 0 0 0 cafe0005 00000000 03
subcc         8ea14006 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 2 1 0 0 cafe0005 0bad0006 07
andn          90298005 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 8 0 0 0 0bad0006 cafe0005 08
sra_imm       93396004 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 c 0 0 0 cafe0005 00000000 09
ldub          d4096008 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 1 0 0 0 0 0 0 cafe0005 00000000 0a
ldsh          d6518005 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 1 0 1 0 0 0 1 0bad0006 cafe0005 0b
ld            d8016010 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 1 0 2 0 0 0 0 cafe0005 00000000 0c
sth           cc316004 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 0 0 1 1 0 0 0 0 cafe0005 00000000 06
call          40000100 00001000 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00001400 1 0 0 0 0 0 0 0 00000000 00000000 0f
bne_annul     32bffffc 00002000 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00001ff0 0 0 0 0 0 0 1 0 00000000 00000000 19
ba_no_annul   10bfff00 00010000 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    0000fc00 0 0 0 0 0 0 0 0 00000000 00000000 08
fwd_ex        82014006 00000100 0 00 00000000 11111111 22222222 33333333 1 0 0 0
    00000000 1 0 0 0 0 0 0 0 11111111 0bad0006 01
fwd_mem       82014006 00000100 0 00 00000000 11111111 22222222 33333333 2 1 0 0
    00000000 1 0 0 0 0 0 0 0 22222222 11111111 01
fwd_wb        82014006 00000100 0 00 00000000 11111111 22222222 33333333 3 2 0 0
    00000000 1 0 0 0 0 0 0 0 33333333 22222222 01
fwd_mix       82014006 00000100 0 00 00000000 11111111 22222222 33333333 0 3 0 0
    00000000 1 0 0 0 0 0 0 0 cafe0005 33333333 01
addcc         88814006 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 1 0 0 cafe0005 0bad0006 04
addcc_stall   88814006 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 1
    00000000 0 0 0 0 0 0 0 0 cafe0005 0bad0006 04
wb_same_cycle 82024000 00000100 1 09 12345678 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 0 0 0 00000000 00000000 01
wb_next       82024000 00000100 0 00 00000000 11111111 22222222 33333333 0 0 0 0
    00000000 1 0 0 0 0 0 0 0 12345678 00000000 01
